//--- cop_alu.sv
`timescale 1ns/1ps

module cop_alu (
    input  cop_pkg::cop_op_e op,
    input  cop_pkg::word_t   a,
    input  cop_pkg::word_t   b,
    output cop_pkg::word_t   result
);

    logic [5:0]     pop_cnt;
    cop_pkg::word_t rev8;
    cop_pkg::word_t min_s;
    cop_pkg::word_t max_u;

    // Ones in a, at most 32
    always_comb begin
        pop_cnt = '0;
        for (int i = 0; i < 32; i++) begin
            pop_cnt = pop_cnt + 6'(a[i]);
        end
    end

    // Byte order swap
    assign rev8 = {a[7:0], a[15:8], a[23:16], a[31:24]};

    assign min_s = ($signed(a) < $signed(b)) ? a : b;
    assign max_u = (a > b) ? a : b;

    always_comb begin
        case (op)
            cop_pkg::OP_POPCNT: result = {26'd0, pop_cnt};
            cop_pkg::OP_REV8:   result = rev8;
            cop_pkg::OP_MIN:    result = min_s;
            cop_pkg::OP_MAXU:   result = max_u;
            // Accumulator ops and the rest are handled outside
            default:            result = '0;
        endcase
    end

endmodule

//--- cop_cases.txt
// opfield rs1_data rs2_data imm allow, then expected accept valid w_data exc, then flush
// All hex; opfield is {funct7, funct3, opcode}, custom-0 opcode 0B
0000B F0F00001 00000000 00000000 1 1 1 00000009 0 0
0000B FFFFFFFF 00000000 00000000 1 1 1 00000020 0 0
0008B 12345678 00000000 00000000 1 1 1 78563412 0 0
0008B A1B2C3D4 00000000 00000000 1 1 1 D4C3B2A1 0 0
0010B FFFFFFF6 00000005 00000000 1 1 1 FFFFFFF6 0 0
0010B 00000007 80000000 00000000 1 1 1 80000000 0 0
0010B 00000042 00000042 00000000 1 1 1 00000042 0 0
0018B FFFFFFF6 00000005 00000000 1 1 1 FFFFFFF6 0 0
0018B 00001000 7FFFFFFF 00000000 1 1 1 7FFFFFFF 0 0
0020B 00000010 00000000 00000005 1 1 1 00000015 0 0
0020B 00000100 00000000 FFFFFFFF 1 1 1 00000114 0 0
0020B 00001000 00000000 00000000 0 1 0 00000000 0 0
0028B 00000000 00000000 00000000 1 1 1 00000114 0 0
0020B 00000003 00000000 00000004 1 1 1 00000007 0 0
0030B 12345678 00000000 00000000 1 1 1 00000000 1 0
0038B 00000000 00000000 00000000 1 1 1 00000000 1 0
0030B 00000000 00000000 00000000 0 1 0 00000000 0 0
0040B FFFFFFFF 00000000 00000000 1 0 0 00000000 0 0
0002B FFFFFFFF 00000000 00000000 1 0 0 00000000 0 0
0000B FFFFFFFF 00000000 00000000 0 1 0 00000000 0 0
0020B 00000020 00000000 00000001 1 1 1 00000028 0 0
0020B 00001000 00000000 00000000 1 1 1 00001028 0 0
0028B 00000000 00000000 00000000 1 1 1 00001028 0 0
00000 00000000 00000000 00000000 0 0 0 00000000 0 1
0028B 00000000 00000000 00000000 1 1 1 00000028 0 0
0020B FFFFFFFF 00000000 00000002 1 1 1 00000001 0 0
0000B 00000000 00000000 00000000 1 1 1 00000000 0 0
0018B 00000000 00000000 00000000 1 1 1 00000000 0 0

//--- cop_decode.sv
`timescale 1ns/1ps

module cop_decode #(
    parameter cop_pkg::opcode_t COP_OPCODE = cop_pkg::COP_OPCODE_DEFAULT
) (
    input  cop_pkg::opfield_t opfield,
    output cop_pkg::cop_dec_t dec
);

    logic            match;
    cop_pkg::cop_op_e op;

    // Our opcode space, and only the funct7 == 0 page of it
    assign match = (opfield.opcode == COP_OPCODE) && (opfield.funct7 == 7'd0);

    always_comb begin
        case (opfield.funct3)
            3'd0:    op = cop_pkg::OP_POPCNT;
            3'd1:    op = cop_pkg::OP_REV8;
            3'd2:    op = cop_pkg::OP_MIN;
            3'd3:    op = cop_pkg::OP_MAXU;
            3'd4:    op = cop_pkg::OP_ACC_ADD;
            3'd5:    op = cop_pkg::OP_ACC_CLR;
            // 6 and 7 are claimed but trap
            default: op = cop_pkg::OP_ILLEGAL;
        endcase
    end

    always_comb begin
        dec = '0;
        if (match) begin
            dec.accept    = 1'b1;
            dec.op        = op;
            dec.writes_rd = (op != cop_pkg::OP_ILLEGAL);
        end
    end

endmodule

//--- cop_pkg.sv
package cop_pkg;

    // Data word for PC, operands, immediate and write data
    typedef logic [31:0] word_t;

    // Register file index
    typedef logic [4:0] reg_idx_t;

    // Major opcode, bits 6 to 0 of the instruction
    typedef logic [6:0] opcode_t;

    // Exception cause as reported to the core
    typedef logic [3:0] exc_code_t;

    // Opcode field as the core hands it over, funct7 in the top bits
    typedef struct packed {
        logic [6:0] funct7;
        logic [2:0] funct3;
        opcode_t    opcode;
    } opfield_t;

    // Operations of the custom space
    typedef enum logic [2:0] {
        OP_NONE    = 3'd0,
        OP_POPCNT  = 3'd1,
        OP_REV8    = 3'd2,
        OP_MIN     = 3'd3,
        OP_MAXU    = 3'd4,
        OP_ACC_ADD = 3'd5,
        OP_ACC_CLR = 3'd6,
        OP_ILLEGAL = 3'd7
    } cop_op_e;

    // Decoded word, one word wide, passed check to ready to exec
    typedef struct packed {
        logic        accept;
        cop_op_e     op;
        logic        writes_rd;
        logic [26:0] reserved;
    } cop_dec_t;

    // Exception codes
    localparam exc_code_t EXC_NONE    = 4'd0;
    localparam exc_code_t EXC_ILLEGAL = 4'd2;

    // custom-0
    localparam opcode_t COP_OPCODE_DEFAULT = 7'b0001011;

endpackage

//--- cop_top.sv
`timescale 1ns/1ps

module cop_top #(
    parameter cop_pkg::opcode_t COP_OPCODE = cop_pkg::COP_OPCODE_DEFAULT
) (
    input  logic                CLK,
    input  logic                reset,
    input  logic                flush,
    input  logic                stall,
    input  logic                mem_wait,

    // Check
    input  cop_pkg::word_t      c_pc,
    input  cop_pkg::opfield_t   c_opfield,
    input  cop_pkg::reg_idx_t   c_rd,
    input  cop_pkg::reg_idx_t   c_rs1,
    input  cop_pkg::reg_idx_t   c_rs2,
    input  cop_pkg::word_t      c_imm,
    output logic                c_accept,
    output cop_pkg::word_t      c_pc_o,
    output cop_pkg::reg_idx_t   c_rd_o,
    output cop_pkg::reg_idx_t   c_rs1_o,
    output cop_pkg::reg_idx_t   c_rs2_o,

    // Exec
    input  logic                e_allow,
    input  cop_pkg::word_t      e_rs1_data,
    input  cop_pkg::word_t      e_rs2_data,
    output logic                e_allow_o,
    output logic                e_valid,
    output cop_pkg::word_t      e_pc,
    output logic                e_reg_w_en,
    output cop_pkg::reg_idx_t   e_reg_w_rd,
    output cop_pkg::word_t      e_reg_w_data,
    output logic                e_exc_en,
    output cop_pkg::exc_code_t  e_exc_code
);

    // Per-slot instruction fields that ride along with the opcode
    typedef struct packed {
        cop_pkg::word_t    pc;
        cop_pkg::reg_idx_t rd;
        cop_pkg::reg_idx_t rs1;
        cop_pkg::reg_idx_t rs2;
        cop_pkg::word_t    imm;
    } slot_t;

    logic              hold;
    cop_pkg::opfield_t opfield_q;
    cop_pkg::cop_dec_t dec_c;
    cop_pkg::cop_dec_t dec_q [1:2];
    slot_t             slot_q [0:2];
    logic              allow_q;
    cop_pkg::word_t    rs1_data_q;
    cop_pkg::word_t    rs2_data_q;

    assign hold = stall || mem_wait;

    always_ff @(posedge CLK) begin
        if (reset || flush) begin
            opfield_q <= '0;
            dec_q[1]  <= '0;
            dec_q[2]  <= '0;
            slot_q[0] <= '0;
            slot_q[1] <= '0;
            slot_q[2] <= '0;
            allow_q   <= 1'b0;
        end else if (!hold) begin
            opfield_q <= c_opfield;
            dec_q[1]  <= dec_c;
            dec_q[2]  <= dec_q[1];
            slot_q[0] <= '{pc: c_pc, rd: c_rd, rs1: c_rs1, rs2: c_rs2, imm: c_imm};
            slot_q[1] <= slot_q[0];
            slot_q[2] <= slot_q[1];
            allow_q   <= e_allow;
        end
    end

    // Operands arrive during ready, land next to slot 2
    always_ff @(posedge CLK) begin
        if (!hold) begin
            rs1_data_q <= e_rs1_data;
            rs2_data_q <= e_rs2_data;
        end
    end

    cop_decode #(
        .COP_OPCODE (COP_OPCODE)
    ) i_cop_decode (
        .opfield (opfield_q),
        .dec     (dec_c)
    );

    assign c_accept = dec_c.accept;
    assign c_pc_o   = slot_q[0].pc;
    assign c_rd_o   = slot_q[0].rd;
    assign c_rs1_o  = slot_q[0].rs1;
    assign c_rs2_o  = slot_q[0].rs2;

    assign e_allow_o = allow_q;
    assign e_pc      = slot_q[2].pc;

    cop_unit i_cop_unit (
        .CLK        (CLK),
        .reset      (reset),
        .hold       (hold),
        .dec        (dec_q[2]),
        .allow      (allow_q),
        .rd         (slot_q[2].rd),
        .imm        (slot_q[2].imm),
        .rs1_data   (rs1_data_q),
        .rs2_data   (rs2_data_q),
        .valid      (e_valid),
        .reg_w_en   (e_reg_w_en),
        .reg_w_rd   (e_reg_w_rd),
        .reg_w_data (e_reg_w_data),
        .exc_en     (e_exc_en),
        .exc_code   (e_exc_code)
    );

    // Exec slot frozen while the core holds the pipe
    a_exec_stable: assert property (
        @(posedge CLK) disable iff (reset)
        (hold && !flush) |=> ($stable(dec_q[2]) && $stable(slot_q[2]) &&
                              $stable(allow_q) && $stable(rs1_data_q) &&
                              $stable(rs2_data_q))
    );

endmodule

//--- cop_unit.sv
`timescale 1ns/1ps

module cop_unit (
    input  logic                CLK,
    input  logic                reset,
    input  logic                hold,
    input  cop_pkg::cop_dec_t   dec,
    input  logic                allow,
    input  cop_pkg::reg_idx_t   rd,
    input  cop_pkg::word_t      imm,
    input  cop_pkg::word_t      rs1_data,
    input  cop_pkg::word_t      rs2_data,
    output logic                valid,
    output logic                reg_w_en,
    output cop_pkg::reg_idx_t   reg_w_rd,
    output cop_pkg::word_t      reg_w_data,
    output logic                exc_en,
    output cop_pkg::exc_code_t  exc_code
);

    cop_pkg::word_t acc_q;
    cop_pkg::word_t acc_sum;
    cop_pkg::word_t alu_result;

    cop_alu i_cop_alu (
        .op     (dec.op),
        .a      (rs1_data),
        .b      (rs2_data),
        .result (alu_result)
    );

    // Core may still cancel at exec
    assign valid = dec.accept && allow;

    assign acc_sum = acc_q + rs1_data + imm;

    // Survives flush, only reset clears it
    always_ff @(posedge CLK) begin
        if (reset) begin
            acc_q <= '0;
        end else if (valid && !hold) begin
            if (dec.op == cop_pkg::OP_ACC_ADD) begin
                acc_q <= acc_sum;
            end else if (dec.op == cop_pkg::OP_ACC_CLR) begin
                acc_q <= '0;
            end
        end
    end

    always_comb begin
        case (dec.op)
            cop_pkg::OP_ACC_ADD: reg_w_data = acc_sum;
            // Old value goes out as the register clears
            cop_pkg::OP_ACC_CLR: reg_w_data = acc_q;
            default:             reg_w_data = alu_result;
        endcase
    end

    assign reg_w_en = valid && dec.writes_rd;
    assign reg_w_rd = rd;
    assign exc_en   = valid && (dec.op == cop_pkg::OP_ILLEGAL);
    assign exc_code = exc_en ? cop_pkg::EXC_ILLEGAL : cop_pkg::EXC_NONE;

    // Decoder must never mark a trapping op as a writer
    a_wr_xor_exc: assert property (
        @(posedge CLK) disable iff (reset)
        !(reg_w_en && exc_en)
    );

endmodule

//--- files.f
cop_pkg.sv
cop_decode.sv
cop_alu.sv
cop_unit.sv
cop_top.sv
tb_cop_checker.sv
tb_cop.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f files.f --top-module tb_cop -Mdir obj_dir -o sim_cop
./obj_dir/sim_cop > sim.log 2>&1
cat sim.log
if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
exit 0

//--- tb_cop.sv
`timescale 1ns/1ps

module tb_cop;

    localparam int MAX_CASES      = 64;
    localparam int WORDS_PER_CASE = 10;

    // One line of the case file
    typedef struct packed {
        cop_pkg::opfield_t opfield;
        cop_pkg::word_t    rs1_data;
        cop_pkg::word_t    rs2_data;
        cop_pkg::word_t    imm;
        logic              allow;
        logic              accept;
        logic              valid;
        cop_pkg::word_t    w_data;
        logic              exc;
        logic              flush;
    } case_t;

    logic               CLK;
    logic               reset;
    logic               flush;
    logic               stall;
    logic               mem_wait;
    cop_pkg::word_t     c_pc;
    cop_pkg::opfield_t  c_opfield;
    cop_pkg::reg_idx_t  c_rd;
    cop_pkg::reg_idx_t  c_rs1;
    cop_pkg::reg_idx_t  c_rs2;
    cop_pkg::word_t     c_imm;
    logic               e_allow;
    cop_pkg::word_t     e_rs1_data;
    cop_pkg::word_t     e_rs2_data;

    logic               c_accept;
    cop_pkg::word_t     c_pc_o;
    cop_pkg::reg_idx_t  c_rd_o;
    cop_pkg::reg_idx_t  c_rs1_o;
    cop_pkg::reg_idx_t  c_rs2_o;
    logic               e_allow_o;
    logic               e_valid;
    cop_pkg::word_t     e_pc;
    logic               e_reg_w_en;
    cop_pkg::reg_idx_t  e_reg_w_rd;
    cop_pkg::word_t     e_reg_w_data;
    logic               e_exc_en;
    cop_pkg::exc_code_t e_exc_code;

    // Expected results of the case now on the check inputs
    logic               exp_accept;
    logic               exp_allow;
    logic               exp_valid;
    logic               exp_exc;
    cop_pkg::word_t     exp_data;
    cop_pkg::word_t     exp_pc;
    cop_pkg::reg_idx_t  exp_rd;
    cop_pkg::reg_idx_t  exp_rs1;
    cop_pkg::reg_idx_t  exp_rs2;

    logic [31:0]        case_words [0:MAX_CASES*WORDS_PER_CASE-1];
    case_t              cases [0:MAX_CASES-1];
    int                 num_cases;
    int                 slot_n;
    int                 cycles;
    int                 timeout_limit;
    int                 setup_errors;
    int                 n_checks;
    int                 n_errors;
    logic [15:0]        lfsr;
    logic               prev_bit;

    cop_top #(
        .COP_OPCODE (cop_pkg::COP_OPCODE_DEFAULT)
    ) i_cop_top (
        .CLK          (CLK),
        .reset        (reset),
        .flush        (flush),
        .stall        (stall),
        .mem_wait     (mem_wait),
        .c_pc         (c_pc),
        .c_opfield    (c_opfield),
        .c_rd         (c_rd),
        .c_rs1        (c_rs1),
        .c_rs2        (c_rs2),
        .c_imm        (c_imm),
        .c_accept     (c_accept),
        .c_pc_o       (c_pc_o),
        .c_rd_o       (c_rd_o),
        .c_rs1_o      (c_rs1_o),
        .c_rs2_o      (c_rs2_o),
        .e_allow      (e_allow),
        .e_rs1_data   (e_rs1_data),
        .e_rs2_data   (e_rs2_data),
        .e_allow_o    (e_allow_o),
        .e_valid      (e_valid),
        .e_pc         (e_pc),
        .e_reg_w_en   (e_reg_w_en),
        .e_reg_w_rd   (e_reg_w_rd),
        .e_reg_w_data (e_reg_w_data),
        .e_exc_en     (e_exc_en),
        .e_exc_code   (e_exc_code)
    );

    tb_cop_checker i_tb_cop_checker (
        .CLK          (CLK),
        .reset        (reset),
        .flush        (flush),
        .stall        (stall),
        .mem_wait     (mem_wait),
        .exp_accept   (exp_accept),
        .exp_allow    (exp_allow),
        .exp_valid    (exp_valid),
        .exp_exc      (exp_exc),
        .exp_data     (exp_data),
        .exp_pc       (exp_pc),
        .exp_rd       (exp_rd),
        .exp_rs1      (exp_rs1),
        .exp_rs2      (exp_rs2),
        .c_accept     (c_accept),
        .c_pc_o       (c_pc_o),
        .c_rd_o       (c_rd_o),
        .c_rs1_o      (c_rs1_o),
        .c_rs2_o      (c_rs2_o),
        .e_allow_o    (e_allow_o),
        .e_pc         (e_pc),
        .e_valid      (e_valid),
        .e_reg_w_en   (e_reg_w_en),
        .e_reg_w_rd   (e_reg_w_rd),
        .e_reg_w_data (e_reg_w_data),
        .e_exc_en     (e_exc_en),
        .e_exc_code   (e_exc_code),
        .n_checks     (n_checks),
        .n_errors     (n_errors)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic load_cases();
        int base;
        // Words past the end of the file keep a nonzero top half
        for (int i = 0; i < MAX_CASES * WORDS_PER_CASE; i++) begin
            case_words[i] = {16'hFFFF, 16'(i)};
        end
        $readmemh("cop_cases.txt", case_words);
        num_cases = 0;
        while (num_cases < MAX_CASES &&
               case_words[num_cases * WORDS_PER_CASE][31:17] == '0) begin
            base = num_cases * WORDS_PER_CASE;
            cases[num_cases].opfield  = case_words[base][16:0];
            cases[num_cases].rs1_data = case_words[base + 1];
            cases[num_cases].rs2_data = case_words[base + 2];
            cases[num_cases].imm      = case_words[base + 3];
            cases[num_cases].allow    = case_words[base + 4][0];
            cases[num_cases].accept   = case_words[base + 5][0];
            cases[num_cases].valid    = case_words[base + 6][0];
            cases[num_cases].w_data   = case_words[base + 7];
            cases[num_cases].exc      = case_words[base + 8][0];
            cases[num_cases].flush    = case_words[base + 9][0];
            num_cases++;
        end
    endtask

    // Inputs for the n-th unstalled edge: case n on check, case n-2 operands
    task automatic drive_slot(input int n);
        case_t cur;
        case_t older;
        logic  bit_now;
        cur   = '0;
        older = '0;
        if (n < num_cases) begin
            cur = cases[n];
        end
        if (n >= 2 && n - 2 < num_cases) begin
            older = cases[n - 2];
        end
        // Nothing sits in ready after a flush, so the core sends no operands
        if (n >= 1 && n - 1 < num_cases && cases[n - 1].flush) begin
            older = '0;
        end
        lfsr    = lfsr_next(lfsr);
        bit_now = lfsr[0];
        c_opfield  <= cur.opfield;
        c_pc       <= cop_pkg::word_t'(n * 4);
        c_rd       <= cop_pkg::reg_idx_t'(n);
        c_rs1      <= cop_pkg::reg_idx_t'(n + 1);
        c_rs2      <= cop_pkg::reg_idx_t'(n + 2);
        c_imm      <= cur.imm;
        flush      <= cur.flush;
        // Exec slot must resolve on a flush edge
        // The bit before a set bit chooses stall or memory wait
        stall      <= bit_now && prev_bit && !cur.flush;
        mem_wait   <= bit_now && !prev_bit && !cur.flush;
        e_allow    <= older.allow;
        e_rs1_data <= older.rs1_data;
        e_rs2_data <= older.rs2_data;
        exp_accept <= cur.accept;
        exp_allow  <= cur.allow;
        exp_valid  <= cur.valid;
        exp_exc    <= cur.exc;
        exp_data   <= cur.w_data;
        exp_pc     <= cop_pkg::word_t'(n * 4);
        exp_rd     <= cop_pkg::reg_idx_t'(n);
        exp_rs1    <= cop_pkg::reg_idx_t'(n + 1);
        exp_rs2    <= cop_pkg::reg_idx_t'(n + 2);
        prev_bit = bit_now;
    endtask

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    initial begin
        reset      = 1'b1;
        flush      = 1'b0;
        stall      = 1'b0;
        mem_wait   = 1'b0;
        c_pc       = '0;
        c_opfield  = '0;
        c_rd       = '0;
        c_rs1      = '0;
        c_rs2      = '0;
        c_imm      = '0;
        e_allow    = 1'b0;
        e_rs1_data = '0;
        e_rs2_data = '0;
        exp_accept = 1'b0;
        exp_allow  = 1'b0;
        exp_valid  = 1'b0;
        exp_exc    = 1'b0;
        exp_data   = '0;
        exp_pc     = '0;
        exp_rd     = '0;
        exp_rs1    = '0;
        exp_rs2    = '0;
        lfsr         = 16'd27;
        prev_bit     = 1'b0;
        slot_n       = 0;
        setup_errors = 0;
        load_cases();
        timeout_limit = 4 * num_cases + 100;
        if (num_cases == 0) begin
            $display("No cases could be read from cop_cases.txt");
            setup_errors++;
        end
        repeat (16) @(posedge CLK);
        reset <= 1'b0;
        drive_slot(0);
        // Three extra slots drain the last case out of exec
        while (slot_n < num_cases + 4) begin
            @(posedge CLK);
            if (!(stall || mem_wait)) begin
                slot_n++;
            end
            drive_slot(slot_n);
        end
        @(negedge CLK);
        $display("cases: %0d  checks: %0d  mismatches: %0d  setup errors: %0d",
                 num_cases, n_checks, n_errors, setup_errors);
        if (n_errors == 0 && setup_errors == 0 && n_checks > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        @(posedge CLK);
        while (cycles < timeout_limit) begin
            @(posedge CLK);
            cycles++;
        end
        $display("Timeout: run still going after %0d cycles", timeout_limit);
        $display("cases: %0d  checks: %0d  mismatches: %0d", num_cases, n_checks, n_errors);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- tb_cop_checker.sv
`timescale 1ns/1ps

module tb_cop_checker (
    input  logic               CLK,
    input  logic               reset,
    input  logic               flush,
    input  logic               stall,
    input  logic               mem_wait,
    input  logic               exp_accept,
    input  logic               exp_allow,
    input  logic               exp_valid,
    input  logic               exp_exc,
    input  cop_pkg::word_t     exp_data,
    input  cop_pkg::word_t     exp_pc,
    input  cop_pkg::reg_idx_t  exp_rd,
    input  cop_pkg::reg_idx_t  exp_rs1,
    input  cop_pkg::reg_idx_t  exp_rs2,
    input  logic               c_accept,
    input  cop_pkg::word_t     c_pc_o,
    input  cop_pkg::reg_idx_t  c_rd_o,
    input  cop_pkg::reg_idx_t  c_rs1_o,
    input  cop_pkg::reg_idx_t  c_rs2_o,
    input  logic               e_allow_o,
    input  cop_pkg::word_t     e_pc,
    input  logic               e_valid,
    input  logic               e_reg_w_en,
    input  cop_pkg::reg_idx_t  e_reg_w_rd,
    input  cop_pkg::word_t     e_reg_w_data,
    input  logic               e_exc_en,
    input  cop_pkg::exc_code_t e_exc_code,
    output int                 n_checks,
    output int                 n_errors
);

    typedef struct packed {
        logic              accept;
        logic              allow;
        logic              valid;
        logic              exc;
        cop_pkg::word_t    data;
        cop_pkg::word_t    pc;
        cop_pkg::reg_idx_t rd;
        cop_pkg::reg_idx_t rs1;
        cop_pkg::reg_idx_t rs2;
    } expect_t;

    // Newest entry sits in check, the third newest in exec
    expect_t in_flight [$];

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("MISMATCH time=%0t %s got %h expected %h", $time, name, got, want);
        end
    endtask

    always @(posedge CLK) begin
        expect_t slot0;
        expect_t slot2;
        expect_t entry;
        logic    w_en;
        logic    trap;
        if (reset) begin
            in_flight.delete();
            n_checks = 0;
            n_errors = 0;
        end else if (!(stall || mem_wait)) begin
            slot0 = '0;
            slot2 = '0;
            if (in_flight.size() > 0) begin
                slot0 = in_flight[$];
            end
            if (in_flight.size() > 2) begin
                slot2 = in_flight[in_flight.size() - 3];
            end
            w_en = slot2.valid && !slot2.exc;
            trap = slot2.valid && slot2.exc;
            compare_value("c_accept", 32'(c_accept), 32'(slot0.accept));
            compare_value("c_pc_o", c_pc_o, slot0.pc);
            compare_value("c_rd_o", 32'(c_rd_o), 32'(slot0.rd));
            compare_value("c_rs1_o", 32'(c_rs1_o), 32'(slot0.rs1));
            compare_value("c_rs2_o", 32'(c_rs2_o), 32'(slot0.rs2));
            compare_value("e_allow_o", 32'(e_allow_o), 32'(slot2.allow));
            compare_value("e_pc", e_pc, slot2.pc);
            compare_value("e_valid", 32'(e_valid), 32'(slot2.valid));
            compare_value("e_reg_w_en", 32'(e_reg_w_en), 32'(w_en));
            compare_value("e_exc_en", 32'(e_exc_en), 32'(trap));
            // Illegal instruction cause is 2
            compare_value("e_exc_code", 32'(e_exc_code), trap ? 32'd2 : 32'd0);
            if (w_en) begin
                compare_value("e_reg_w_data", e_reg_w_data, slot2.data);
                compare_value("e_reg_w_rd", 32'(e_reg_w_rd), 32'(slot2.rd));
            end
            if (flush) begin
                // Check and ready are cancelled, exec has just resolved
                in_flight.delete();
            end else begin
                entry.accept = exp_accept;
                entry.allow  = exp_allow;
                entry.valid  = exp_valid;
                entry.exc    = exp_exc;
                entry.data   = exp_data;
                entry.pc     = exp_pc;
                entry.rd     = exp_rd;
                entry.rs1    = exp_rs1;
                entry.rs2    = exp_rs2;
                in_flight.push_back(entry);
                if (in_flight.size() > 3) begin
                    void'(in_flight.pop_front());
                end
            end
        end
    end

endmodule
